// ==== logic/texhist_pkg.sv ====
package texhist_pkg;

    // ####################################################################
    // frame and descriptor geometry
    // ####################################################################
    localparam int FRAME_COLS   = 8;
    localparam int FRAME_ROWS   = 8;
    localparam int FRAME_PIXELS = FRAME_COLS * FRAME_ROWS;
    localparam int WIN_RADIUS   = 2;
    localparam int WIN_TAPS     = 2 * WIN_RADIUS + 1;
    // each value of the center bit owns WIN_TAPS possible neighbor counts
    localparam int NUM_BINS     = 2 * WIN_TAPS;
    localparam int DRAIN_CYCLES = 2;

    typedef logic [7:0]  pixel_t;
    typedef logic [15:0] count_t;
    typedef logic [3:0]  bin_idx_t;
    typedef logic [2:0]  col_t;
    typedef logic [2:0]  row_t;
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        ACCUM,
        DRAIN,
        DONE
    } ctrl_state_t;

    typedef struct packed {
        pixel_t pixel;
        logic   last_in_row;
    } pix_beat_t;

    typedef struct packed {
        logic     valid;
        bin_idx_t bin;
    } hist_incr_t;

    // ####################################################################
    // register map
    // ####################################################################
    localparam axil_addr_t REG_CTRL     = 8'h00;
    localparam axil_addr_t REG_THRESH   = 8'h04;
    localparam axil_addr_t REG_STATUS   = 8'h08;
    localparam axil_addr_t REG_BIN_BASE = 8'h40;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== logic/axil_regs.sv ====
`timescale 1ns/1ps

module axil_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  texhist_pkg::axil_addr_t s_axil_awaddr_i,
    input  logic                    s_axil_awvalid_i,
    output logic                    s_axil_awready_o,
    input  texhist_pkg::axil_data_t s_axil_wdata_i,
    input  logic [3:0]              s_axil_wstrb_i,
    input  logic                    s_axil_wvalid_i,
    output logic                    s_axil_wready_o,
    output logic [1:0]              s_axil_bresp_o,
    output logic                    s_axil_bvalid_o,
    input  logic                    s_axil_bready_i,
    input  texhist_pkg::axil_addr_t s_axil_araddr_i,
    input  logic                    s_axil_arvalid_i,
    output logic                    s_axil_arready_o,
    output texhist_pkg::axil_data_t s_axil_rdata_o,
    output logic [1:0]              s_axil_rresp_o,
    output logic                    s_axil_rvalid_o,
    input  logic                    s_axil_rready_i,
    input  logic                    busy_i,
    input  logic                    done_i,
    input  texhist_pkg::count_t     bin_count_i,
    output logic                    start_o,
    output texhist_pkg::pixel_t     thresh_o,
    output texhist_pkg::bin_idx_t   bin_rd_idx_o
);
    import texhist_pkg::*;

    logic       aw_held_q;
    logic       w_held_q;
    axil_addr_t awaddr_q;
    axil_data_t wdata_q;
    logic [3:0] wstrb_q;
    logic       aw_hs;
    logic       w_hs;
    logic       wr_fire;
    axil_addr_t wr_addr;
    axil_data_t wr_data;
    logic [3:0] wr_strb;
    logic       ar_hs;
    axil_addr_t bin_off;
    logic       bin_hit;
    axil_data_t rd_data;
    logic [1:0] rd_resp;

    // ####################################################################
    // write path
    // ####################################################################

    // address and data may arrive in either order and a held channel waits for the other
    assign s_axil_awready_o = !aw_held_q && !s_axil_bvalid_o;
    assign s_axil_wready_o  = !w_held_q && !s_axil_bvalid_o;
    assign aw_hs   = s_axil_awvalid_i && s_axil_awready_o;
    assign w_hs    = s_axil_wvalid_i && s_axil_wready_o;
    assign wr_fire = (aw_held_q || aw_hs) && (w_held_q || w_hs);
    assign wr_addr = aw_held_q ? awaddr_q : s_axil_awaddr_i;
    assign wr_data = w_held_q ? wdata_q : s_axil_wdata_i;
    assign wr_strb = w_held_q ? wstrb_q : s_axil_wstrb_i;

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            awaddr_q <= s_axil_awaddr_i;
        end
        if (w_hs) begin
            wdata_q <= s_axil_wdata_i;
            wstrb_q <= s_axil_wstrb_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_held_q       <= 1'b0;
            w_held_q        <= 1'b0;
            s_axil_bvalid_o <= 1'b0;
            s_axil_bresp_o  <= RESP_OKAY;
            start_o         <= 1'b0;
            thresh_o        <= '0;
        end else begin
            start_o <= 1'b0;
            if (wr_fire) begin
                aw_held_q       <= 1'b0;
                w_held_q        <= 1'b0;
                s_axil_bvalid_o <= 1'b1;
                s_axil_bresp_o  <= RESP_OKAY;
                case (wr_addr)
                    REG_CTRL:   start_o <= wr_strb[0] && wr_data[0];
                    REG_THRESH: begin
                        if (wr_strb[0]) begin
                            thresh_o <= wr_data[7:0];
                        end
                    end
                    default:    s_axil_bresp_o <= RESP_SLVERR;
                endcase
            end else begin
                if (aw_hs) begin
                    aw_held_q <= 1'b1;
                end
                if (w_hs) begin
                    w_held_q <= 1'b1;
                end
            end
            if (s_axil_bvalid_o && s_axil_bready_i) begin
                s_axil_bvalid_o <= 1'b0;
            end
        end
    end

    // ####################################################################
    // read path
    // ####################################################################
    assign s_axil_arready_o = !s_axil_rvalid_o;
    assign ar_hs   = s_axil_arvalid_i && s_axil_arready_o;
    assign bin_off = s_axil_araddr_i - REG_BIN_BASE;
    assign bin_hit = (s_axil_araddr_i >= REG_BIN_BASE) && (bin_off[1:0] == 2'b00)
                     && (bin_off[7:2] < 6'(NUM_BINS));
    // the histogram answers in the same cycle, so the index comes straight off araddr
    assign bin_rd_idx_o = bin_off[5:2];

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (s_axil_araddr_i)
            REG_CTRL:   rd_data = '0;
            REG_THRESH: rd_data = axil_data_t'(thresh_o);
            REG_STATUS: rd_data = {30'd0, done_i, busy_i};
            default: begin
                if (bin_hit) begin
                    rd_data = axil_data_t'(bin_count_i);
                end else begin
                    rd_resp = RESP_SLVERR;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            s_axil_rdata_o <= rd_data;
            s_axil_rresp_o <= rd_resp;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axil_rvalid_o <= 1'b0;
        end else if (ar_hs) begin
            s_axil_rvalid_o <= 1'b1;
        end else if (s_axil_rready_i) begin
            s_axil_rvalid_o <= 1'b0;
        end
    end

endmodule

// ==== logic/frame_ctrl.sv ====
`timescale 1ns/1ps

module frame_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start_i,
    input  logic clear_last_i,
    input  logic frame_last_i,
    output logic clear_en_o,
    output logic accum_en_o,
    output logic busy_o,
    output logic done_o
);
    import texhist_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic [1:0]  drain_cnt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            // a start during CLEAR, ACCUM or DRAIN has no effect
            IDLE, DONE: begin
                if (start_i) begin
                    state_d = CLEAR;
                end
            end
            CLEAR: begin
                if (clear_last_i) begin
                    state_d = ACCUM;
                end
            end
            ACCUM: begin
                if (frame_last_i) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (drain_cnt_q == '0) begin
                    state_d = DONE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            drain_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            // the last increment is still two stages deep when DRAIN is entered
            if (state_q == ACCUM) begin
                drain_cnt_q <= 2'(DRAIN_CYCLES - 1);
            end else if (state_q == DRAIN && drain_cnt_q != '0) begin
                drain_cnt_q <= drain_cnt_q - 2'd1;
            end
        end
    end

    assign clear_en_o = (state_q == CLEAR);
    assign accum_en_o = (state_q == ACCUM);
    assign busy_o     = (state_q == CLEAR) || (state_q == ACCUM) || (state_q == DRAIN);
    assign done_o     = (state_q == DONE);

endmodule

// ==== logic/pixel_position.sv ====
`timescale 1ns/1ps

module pixel_position (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   accept_i,
    input  texhist_pkg::pixel_t    pixel_i,
    input  logic                   clear_en_i,
    output texhist_pkg::pix_beat_t beat_o,
    output logic                   beat_valid_o,
    output texhist_pkg::bin_idx_t  clear_addr_o,
    output logic                   clear_last_o,
    output logic                   frame_last_o
);
    import texhist_pkg::*;

    col_t       col_q;
    row_t       row_q;
    logic [5:0] pix_idx;

    // row and column read together as one linear index into the frame
    assign pix_idx      = {row_q, col_q};
    // during clear the same counters walk the bins
    assign clear_addr_o = bin_idx_t'(pix_idx);
    assign clear_last_o = clear_en_i && (pix_idx == 6'(NUM_BINS - 1));
    assign frame_last_o = accept_i && (pix_idx == 6'(FRAME_PIXELS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_q        <= '0;
            row_q        <= '0;
            beat_valid_o <= 1'b0;
        end else begin
            beat_valid_o <= accept_i;
            if (clear_last_o || frame_last_o) begin
                col_q <= '0;
                row_q <= '0;
            end else if (accept_i || clear_en_i) begin
                if (col_q == col_t'(FRAME_COLS - 1)) begin
                    col_q <= '0;
                    row_q <= row_q + row_t'(1);
                end else begin
                    col_q <= col_q + col_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            beat_o.pixel       <= pixel_i;
            beat_o.last_in_row <= (col_q == col_t'(FRAME_COLS - 1));
        end
    end

endmodule

// ==== logic/pattern_coder.sv ====
`timescale 1ns/1ps

module pattern_coder (
    input  logic                    clk,
    input  logic                    rst_n,
    input  texhist_pkg::pix_beat_t  beat_i,
    input  logic                    beat_valid_i,
    input  texhist_pkg::pixel_t     thresh_i,
    output texhist_pkg::hist_incr_t incr_o
);
    import texhist_pkg::*;

    // older pixels of the window, index 0 is the most recent
    pixel_t     win_q [WIN_TAPS-1];
    pixel_t     taps  [WIN_TAPS];
    pixel_t     center;
    bin_idx_t   above;
    bin_idx_t   bin_d;
    bin_idx_t   bin_q;
    logic [2:0] fill_q;
    logic       valid_q;

    always_comb begin
        taps[0] = beat_i.pixel;
        for (int i = 1; i < WIN_TAPS; i++) begin
            taps[i] = win_q[i-1];
        end
        center = taps[WIN_RADIUS];
        above  = '0;
        for (int i = 0; i < WIN_TAPS; i++) begin
            if (i != WIN_RADIUS && taps[i] >= center) begin
                above = above + bin_idx_t'(1);
            end
        end
        bin_d = (center >= thresh_i) ? above + bin_idx_t'(WIN_TAPS) : above;
    end

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            win_q[0] <= beat_i.pixel;
            for (int i = 1; i < WIN_TAPS - 1; i++) begin
                win_q[i] <= win_q[i-1];
            end
            bin_q <= bin_d;
        end
    end

    // fill saturates once the window holds a full row segment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= beat_valid_i && (fill_q == 3'(WIN_TAPS - 1));
            if (beat_valid_i) begin
                if (beat_i.last_in_row) begin
                    fill_q <= '0;
                end else if (fill_q != 3'(WIN_TAPS - 1)) begin
                    fill_q <= fill_q + 3'd1;
                end
            end
        end
    end

    assign incr_o.valid = valid_q;
    assign incr_o.bin   = bin_q;

endmodule

// ==== logic/joint_histogram.sv ====
`timescale 1ns/1ps

module joint_histogram (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear_en_i,
    input  texhist_pkg::bin_idx_t   clear_addr_i,
    input  texhist_pkg::hist_incr_t incr_i,
    input  texhist_pkg::bin_idx_t   rd_idx_i,
    output texhist_pkg::count_t     rd_count_o
);
    import texhist_pkg::*;

    count_t bins_q [NUM_BINS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_BINS; i++) begin
                bins_q[i] <= '0;
            end
        end else if (clear_en_i) begin
            bins_q[clear_addr_i] <= '0;
        end else if (incr_i.valid) begin
            bins_q[incr_i.bin] <= bins_q[incr_i.bin] + count_t'(1);
        end
    end

    // indices past the last bin read as zero
    assign rd_count_o = (rd_idx_i < bin_idx_t'(NUM_BINS)) ? bins_q[rd_idx_i] : '0;

endmodule

// ==== logic/texhist_top.sv ====
`timescale 1ns/1ps

module texhist_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  texhist_pkg::axil_addr_t s_axil_awaddr_i,
    input  logic                    s_axil_awvalid_i,
    output logic                    s_axil_awready_o,
    input  texhist_pkg::axil_data_t s_axil_wdata_i,
    input  logic [3:0]              s_axil_wstrb_i,
    input  logic                    s_axil_wvalid_i,
    output logic                    s_axil_wready_o,
    output logic [1:0]              s_axil_bresp_o,
    output logic                    s_axil_bvalid_o,
    input  logic                    s_axil_bready_i,
    input  texhist_pkg::axil_addr_t s_axil_araddr_i,
    input  logic                    s_axil_arvalid_i,
    output logic                    s_axil_arready_o,
    output texhist_pkg::axil_data_t s_axil_rdata_o,
    output logic [1:0]              s_axil_rresp_o,
    output logic                    s_axil_rvalid_o,
    input  logic                    s_axil_rready_i,
    input  logic                    pixel_valid_i,
    input  texhist_pkg::pixel_t     pixel_i,
    output logic                    pixel_ready_o
);
    import texhist_pkg::*;

    logic       start;
    logic       busy;
    logic       done;
    logic       clear_en;
    logic       accum_en;
    logic       clear_last;
    logic       frame_last;
    logic       pixel_accept;
    logic       beat_valid;
    pixel_t     thresh;
    bin_idx_t   bin_rd_idx;
    bin_idx_t   clear_addr;
    count_t     bin_count;
    pix_beat_t  beat;
    hist_incr_t incr;

    // the controller state is the only back-pressure on the pixel stream
    assign pixel_ready_o = accum_en;
    assign pixel_accept  = pixel_valid_i && accum_en;

    axil_regs u_regs (
        .*,
        .busy_i       (busy),
        .done_i       (done),
        .bin_count_i  (bin_count),
        .start_o      (start),
        .thresh_o     (thresh),
        .bin_rd_idx_o (bin_rd_idx)
    );

    frame_ctrl u_ctrl (
        .clk,
        .rst_n,
        .start_i      (start),
        .clear_last_i (clear_last),
        .frame_last_i (frame_last),
        .clear_en_o   (clear_en),
        .accum_en_o   (accum_en),
        .busy_o       (busy),
        .done_o       (done)
    );

    pixel_position u_pos (
        .clk,
        .rst_n,
        .accept_i     (pixel_accept),
        .pixel_i      (pixel_i),
        .clear_en_i   (clear_en),
        .beat_o       (beat),
        .beat_valid_o (beat_valid),
        .clear_addr_o (clear_addr),
        .clear_last_o (clear_last),
        .frame_last_o (frame_last)
    );

    pattern_coder u_coder (
        .clk,
        .rst_n,
        .beat_i       (beat),
        .beat_valid_i (beat_valid),
        .thresh_i     (thresh),
        .incr_o       (incr)
    );

    joint_histogram u_hist (
        .clk,
        .rst_n,
        .clear_en_i   (clear_en),
        .clear_addr_i (clear_addr),
        .incr_i       (incr),
        .rd_idx_i     (bin_rd_idx),
        .rd_count_o   (bin_count)
    );

endmodule

// ==== dv/texhist_checker.sv ====
`timescale 1ns/1ps

module texhist_checker (
    input logic                     clk,
    input logic                     rst_n,
    input texhist_pkg::ctrl_state_t state_i,
    input logic                     ready_i,
    input logic                     clear_last_i,
    input logic                     frame_last_i,
    input logic                     busy_i,
    input logic                     done_i
);
    import texhist_pkg::*;

    // pixel_ready_o may open only after the clear has walked every bin
    ready_opens_after_clear: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ready_i) |-> $past(clear_last_i)
    ) else $error("pixel ready rose before the clear finished");

    // and it closes again on the last pixel of the frame
    ready_closes_on_frame_end: assert property (
        @(posedge clk) disable iff (!rst_n) $fell(ready_i) |-> $past(frame_last_i)
    ) else $error("pixel ready fell before the last pixel of the frame");

    busy_done_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(busy_i && done_i)
    ) else $error("busy and done are both high");

    drain_moves_on: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_i == DRAIN) |=> (state_i == DRAIN || state_i == DONE)
    ) else $error("DRAIN left for a state other than DONE");

    // three DRAIN cycles in a row are the longest allowed wait
    drain_bounded: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_i == DRAIN && $past(state_i, 1) == DRAIN && $past(state_i, 2) == DRAIN)
        |=> (state_i == DONE)
    ) else $error("DRAIN did not reach DONE within 3 cycles");

endmodule

bind frame_ctrl texhist_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .state_i      (state_q),
    .ready_i      (accum_en_o),
    .clear_last_i (clear_last_i),
    .frame_last_i (frame_last_i),
    .busy_i       (busy_o),
    .done_i       (done_o)
);

// ==== dv/texhist_tb.sv ====
`timescale 1ns/1ps

module texhist_tb;
    import texhist_pkg::*;

    // ####################################################################
    // case layout and limits
    // ####################################################################
    localparam int NUM_CASES       = 2;
    localparam int CASE_WORDS      = 1 + FRAME_PIXELS + NUM_BINS;
    localparam int CODES_PER_FRAME = FRAME_ROWS * (FRAME_COLS - 2 * WIN_RADIUS);
    localparam int TIMEOUT_CYCLES  = 200;
    localparam int MAX_POLLS       = 50;

    logic        clk = 1'b0;
    logic        rst_n;
    axil_addr_t  awaddr;
    logic        awvalid;
    logic        awready;
    axil_data_t  wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    axil_addr_t  araddr;
    logic        arvalid;
    logic        arready;
    axil_data_t  rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        pix_valid;
    pixel_t      pix_data;
    logic        pix_ready;

    // threshold, pixels and expected bins of every case, back to back
    logic [15:0] cases_mem [NUM_CASES * CASE_WORDS];
    logic [31:0] rng_state;
    int          error_count;
    int          timeout_count;

    texhist_top dut_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .s_axil_awaddr_i  (awaddr),
        .s_axil_awvalid_i (awvalid),
        .s_axil_awready_o (awready),
        .s_axil_wdata_i   (wdata),
        .s_axil_wstrb_i   (wstrb),
        .s_axil_wvalid_i  (wvalid),
        .s_axil_wready_o  (wready),
        .s_axil_bresp_o   (bresp),
        .s_axil_bvalid_o  (bvalid),
        .s_axil_bready_i  (bready),
        .s_axil_araddr_i  (araddr),
        .s_axil_arvalid_i (arvalid),
        .s_axil_arready_o (arready),
        .s_axil_rdata_o   (rdata),
        .s_axil_rresp_o   (rresp),
        .s_axil_rvalid_o  (rvalid),
        .s_axil_rready_i  (rready),
        .pixel_valid_i    (pix_valid),
        .pixel_i          (pix_data),
        .pixel_ready_o    (pix_ready)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        error_count++;
    endtask

    task automatic end_run();
        $display("run complete: %0d errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        timeout_count++;
        end_run();
    endtask

    // ####################################################################
    // AXI4-Lite host
    // ####################################################################
    task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                             output logic [1:0] resp);
        logic aw_done;
        logic w_done;
        int   cycles;
        aw_done = 1'b0;
        w_done  = 1'b0;
        cycles  = 0;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hf;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            // a ready seen at the falling edge means the transfer is on the next rising edge
            if (!aw_done && awready) begin
                aw_done = 1'b1;
            end
            if (!w_done && wready) begin
                w_done = 1'b1;
            end
            @(posedge clk);
            if (aw_done) begin
                awvalid <= 1'b0;
            end
            if (w_done) begin
                wvalid <= 1'b0;
            end
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_on_timeout("the write address and data handshakes");
            end
        end
        cycles = 0;
        @(negedge clk);
        while (!bvalid) begin
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_on_timeout("the write response");
            end
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic read_reg(input axil_addr_t addr, output axil_data_t data,
                            output logic [1:0] resp);
        int cycles;
        cycles = 0;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        @(negedge clk);
        while (!arready) begin
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_on_timeout("the read address handshake");
            end
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!rvalid) begin
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_on_timeout("the read data");
            end
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    // ####################################################################
    // pixel stream and frame checks
    // ####################################################################
    task automatic send_frame(input int base);
        int gap;
        int cycles;
        rng_state = next_random(rng_state);
        gap = int'(rng_state % 8);
        repeat (gap) @(posedge clk);
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            @(posedge clk);
            pix_valid <= 1'b1;
            pix_data  <= pixel_t'(cases_mem[base + 1 + p]);
            cycles = 0;
            @(negedge clk);
            while (!pix_ready) begin
                cycles++;
                if (cycles >= TIMEOUT_CYCLES) begin
                    abort_on_timeout("pixel_ready_o during the frame");
                end
                @(negedge clk);
            end
        end
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    // pixels offered while the engine is not accumulating must be refused
    task automatic offer_blocked_pixels(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            rng_state = next_random(rng_state);
            pix_valid <= 1'b1;
            pix_data  <= pixel_t'(rng_state[7:0]);
            @(negedge clk);
            if (pix_ready) begin
                report_mismatch("pixel_ready_o", 32'(pix_ready), 32'h0);
            end
        end
        @(posedge clk);
        pix_valid <= 1'b0;
    endtask

    task automatic wait_done();
        axil_data_t status;
        logic [1:0] resp;
        int         polls;
        polls = 0;
        read_reg(REG_STATUS, status, resp);
        while (!status[1]) begin
            polls++;
            if (polls >= MAX_POLLS) begin
                abort_on_timeout("done in the status register");
            end
            read_reg(REG_STATUS, status, resp);
        end
        if (status != 32'h2) begin
            report_mismatch("s_axil_rdata_o (status)", status, 32'h2);
        end
    endtask

    task automatic check_bins(input int base);
        axil_data_t data;
        axil_data_t expected;
        logic [1:0] resp;
        int         sum;
        sum = 0;
        for (int k = 0; k < NUM_BINS; k++) begin
            read_reg(REG_BIN_BASE + axil_addr_t'(4 * k), data, resp);
            expected = 32'(cases_mem[base + 1 + FRAME_PIXELS + k]);
            if (resp != RESP_OKAY) begin
                report_mismatch("s_axil_rresp_o", 32'(resp), 32'(RESP_OKAY));
            end
            if (data != expected) begin
                report_mismatch($sformatf("s_axil_rdata_o (bin %0d)", k), data, expected);
            end
            sum += int'(data);
        end
        if (sum != CODES_PER_FRAME) begin
            report_mismatch("sum of s_axil_rdata_o over the bins", 32'(sum),
                            32'(CODES_PER_FRAME));
        end
    endtask

    initial begin
        axil_data_t data;
        logic [1:0] resp;
        int         base;
        rst_n         = 1'b0;
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        pix_valid     = 1'b0;
        pix_data      = '0;
        error_count   = 0;
        timeout_count = 0;
        rng_state     = 32'hfa3b6c53;
        $readmemh("dv/texhist_cases.txt", cases_mem);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        read_reg(REG_STATUS, data, resp);
        if (data != '0) begin
            report_mismatch("s_axil_rdata_o (status)", data, 32'h0);
        end
        write_reg(REG_THRESH, 32'h0000_00a5, resp);
        if (resp != RESP_OKAY) begin
            report_mismatch("s_axil_bresp_o", 32'(resp), 32'(RESP_OKAY));
        end
        read_reg(REG_THRESH, data, resp);
        if (data != 32'h0000_00a5) begin
            report_mismatch("s_axil_rdata_o (threshold)", data, 32'h0000_00a5);
        end

        // unmapped register and the first word past the last bin
        write_reg(8'h0c, 32'h1, resp);
        if (resp != RESP_SLVERR) begin
            report_mismatch("s_axil_bresp_o", 32'(resp), 32'(RESP_SLVERR));
        end
        read_reg(8'h0c, data, resp);
        if (resp != RESP_SLVERR) begin
            report_mismatch("s_axil_rresp_o", 32'(resp), 32'(RESP_SLVERR));
        end
        read_reg(REG_BIN_BASE + axil_addr_t'(4 * NUM_BINS), data, resp);
        if (resp != RESP_SLVERR) begin
            report_mismatch("s_axil_rresp_o", 32'(resp), 32'(RESP_SLVERR));
        end

        offer_blocked_pixels(8);

        // frames run back to back, each must show only its own counts
        for (int c = 0; c < NUM_CASES; c++) begin
            base = c * CASE_WORDS;
            write_reg(REG_THRESH, 32'(cases_mem[base]), resp);
            if (resp != RESP_OKAY) begin
                report_mismatch("s_axil_bresp_o", 32'(resp), 32'(RESP_OKAY));
            end
            write_reg(REG_CTRL, 32'h1, resp);
            if (resp != RESP_OKAY) begin
                report_mismatch("s_axil_bresp_o", 32'(resp), 32'(RESP_OKAY));
            end
            send_frame(base);
            wait_done();
            check_bins(base);
            offer_blocked_pixels(8);
            check_bins(base);
        end
        end_run();
    end

endmodule

// ==== dv/texhist_cases.txt ====
// per case: threshold, 64 pixels in raster order with two rows per line,
// then the expected counts of bins 0 to 9
80
00 10 20 30 40 50 60 70 f0 e0 d0 c0 b0 a0 90 80
55 55 55 55 55 55 55 55 80 80 80 80 80 80 80 80
00 ff 00 ff 00 ff 00 ff 10 20 30 90 30 20 10 00
f0 c0 a0 10 a0 c0 f0 ff 7f 80 7f 80 81 7e 90 01
0 0 7 1 8 1 1 8 2 4
40
00 10 20 30 40 50 60 70 01 02 30 05 06 30 02 01
10 20 3f 3f 20 10 00 00 ff ff ff ff ff ff ff ff
00 00 00 00 00 00 00 00 40 3f 41 3e 42 3d 43 3c
90 10 80 20 70 30 60 40 05 04 03 02 01 00 00 00
2 2 8 5 5 0 4 2 0 4

// ==== all.f ====
logic/texhist_pkg.sv
logic/axil_regs.sv
logic/frame_ctrl.sv
logic/pixel_position.sv
logic/pattern_coder.sv
logic/joint_histogram.sv
logic/texhist_top.sv
dv/texhist_checker.sv
dv/texhist_tb.sv

// ==== Makefile ====
# Verilator build and run for the texture histogram engine

VERILATOR ?= verilator
TOP       ?= texhist_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 4

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the log holds the pass line
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
